/* source/degu_pkg.sv */
/*
 * Degu load/store interconnect package.
 * Bus sizes, the address map, size and GPIO register encodings,
 * and the request/response structs shared by every stage.
 */

package degu_pkg;

  ////////////////////
  // bus sizes
  ////////////////////

  // data width and byte lanes
  localparam int unsigned XLEN = 32;
  localparam int unsigned BLEN = XLEN/8;
  localparam int unsigned BLOG = $clog2(BLEN);

  // data memory word address width, 4 KiB
  localparam int unsigned MEM_ADR_W = 10;

  ////////////////////
  // address map
  ////////////////////

  // set for the peripheral window at 0x20_0000
  localparam int unsigned PER_SEL_BIT = 21;
  // inside the peripheral window, GPIO 0x00~0x3f, UART 0x40~0x7f
  localparam int unsigned UART_SEL_BIT = 6;

  // GPIO pin count
  localparam int unsigned GW = 32;

  ////////////////////
  // encodings
  ////////////////////

  // log2 of the transfer size in bytes
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } bus_size_t;

  // GPIO register offsets, address bits 3:2
  typedef enum logic [1:0] {
    GPIO_OUT  = 2'd0,
    GPIO_ENA  = 2'd1,
    GPIO_IN   = 2'd2,
    GPIO_NONE = 2'd3
  } gpio_reg_t;

  ////////////////////
  // bus structs
  ////////////////////

  // request from the load/store port, data right-aligned
  typedef struct packed {
    logic            wen;
    logic [XLEN-1:0] adr;
    bus_size_t       size;
    logic [XLEN-1:0] wdt;
  } lsu_req_t;

  // byte-enable request, data in its lanes
  typedef struct packed {
    logic            wen;
    logic [XLEN-1:0] adr;
    logic [BLEN-1:0] ben;
    logic [XLEN-1:0] wdt;
    logic            mis;
  } ben_req_t;

  // response, full word as stored
  typedef struct packed {
    logic [XLEN-1:0] rdt;
    logic            err;
  } bus_rsp_t;

endpackage: degu_pkg

/* source/lsu_lane_align.sv */
/*
 * Load/store lane alignment.
 * Turns a log-size request into a byte-enable request,
 * shifts write data into the addressed lanes and flags
 * misaligned half and word accesses. Purely combinational.
 */

`timescale 1ns/1ps

module lsu_lane_align (
  input  degu_pkg::lsu_req_t req,
  output degu_pkg::ben_req_t ben_req
);

  // byte offset inside the word
  logic [degu_pkg::BLOG-1:0] off;
  // lanes of the transfer before the shift
  logic [degu_pkg::BLEN-1:0] size_ben;
  // write data cut to the transfer size
  logic [degu_pkg::XLEN-1:0] size_wdt;
  // alignment check
  logic                      mis;

  assign off = req.adr[degu_pkg::BLOG-1:0];

  ////////////////////
  // size decode
  ////////////////////

  always_comb begin
    case (req.size)
      degu_pkg::SIZE_BYTE: begin
        size_ben = 4'b0001;
        size_wdt = {24'h00_0000, req.wdt[7:0]};
        // any offset is fine for a byte
        mis      = 1'b0;
      end
      degu_pkg::SIZE_HALF: begin
        size_ben = 4'b0011;
        size_wdt = {16'h0000, req.wdt[15:0]};
        // odd address
        mis      = off[0];
      end
      degu_pkg::SIZE_WORD: begin
        size_ben = 4'b1111;
        size_wdt = req.wdt;
        // not a multiple of four
        mis      = |off;
      end
      default: begin
        // undefined size code, treated as an error
        size_ben = 4'b0000;
        size_wdt = '0;
        mis      = 1'b1;
      end
    endcase
  end

  ////////////////////
  // lane shift
  ////////////////////

  always_comb begin
    ben_req.wen = req.wen;
    ben_req.adr = req.adr;
    ben_req.ben = size_ben << off;
    // offset in bytes to offset in bits
    ben_req.wdt = size_wdt << {off, 3'b000};
    ben_req.mis = mis;
  end

endmodule: lsu_lane_align

/* source/lsu_bus_decoder.sv */
/*
 * Load/store bus decoder.
 * Sends each accepted request to the data memory or to the
 * peripheral bridge, turns misaligned requests into an error
 * response, keeps responses in order and stalls the request
 * port for one cycle after a peripheral acceptance.
 */

`timescale 1ns/1ps

module lsu_bus_decoder (
  input  logic                          clk,
  input  logic                          rst,
  // request port
  input  logic                          req_vld,
  input  degu_pkg::ben_req_t            ben_req,
  output logic                          req_rdy,
  // data memory
  output logic                          mem_vld,
  output degu_pkg::ben_req_t            mem_req,
  input  logic [degu_pkg::XLEN-1:0]     mem_rdt,
  // peripheral bridge
  output logic                          per_vld,
  output degu_pkg::ben_req_t            per_req,
  input  logic                          per_rsp_vld,
  input  degu_pkg::bus_rsp_t            per_rsp,
  // response port
  output logic                          rsp_vld,
  output degu_pkg::bus_rsp_t            rsp
);

  // what the request of the last cycle expects back
  typedef enum logic [1:0] {
    ORD_NONE   = 2'd0,
    ORD_MEM_RD = 2'd1,
    ORD_MEM_WR = 2'd2,
    ORD_ERR    = 2'd3
  } ord_t;

  logic hsk;
  logic sel_per;
  ord_t ord_d;
  ord_t ord_q;
  // request port blocked for one cycle
  logic stall;

  ////////////////////
  // request side
  ////////////////////

  assign req_rdy = ~stall;
  assign hsk     = req_vld & req_rdy;

  // address map, peripherals above 0x20_0000
  assign sel_per = ben_req.adr[degu_pkg::PER_SEL_BIT];

  // misaligned requests reach neither target
  assign mem_vld = hsk & ~ben_req.mis & ~sel_per;
  assign per_vld = hsk & ~ben_req.mis &  sel_per;
  assign mem_req = ben_req;
  assign per_req = ben_req;

  // record for the response cycle
  always_comb begin
    if (!hsk) begin
      ord_d = ORD_NONE;
    end else if (ben_req.mis) begin
      ord_d = ORD_ERR;
    end else if (sel_per) begin
      // bridge brings its own valid
      ord_d = ORD_NONE;
    end else if (ben_req.wen) begin
      ord_d = ORD_MEM_WR;
    end else begin
      ord_d = ORD_MEM_RD;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ord_q <= ORD_NONE;
      // port stays closed for the first cycle out of reset
      stall <= 1'b1;
    end else begin
      ord_q <= ord_d;
      // keeps the memory response clear of the bridge response
      stall <= per_vld;
    end
  end

  ////////////////////
  // response merge
  ////////////////////

  always_comb begin
    case (ord_q)
      ORD_MEM_RD: begin
        rsp_vld = 1'b1;
        rsp.rdt = mem_rdt;
        rsp.err = 1'b0;
      end
      ORD_MEM_WR: begin
        rsp_vld = 1'b1;
        rsp.rdt = '0;
        rsp.err = 1'b0;
      end
      ORD_ERR: begin
        // rdt zero on error
        rsp_vld = 1'b1;
        rsp.rdt = '0;
        rsp.err = 1'b1;
      end
      default: begin
        rsp_vld = per_rsp_vld;
        rsp     = per_rsp;
      end
    endcase
  end

endmodule: lsu_bus_decoder

/* source/data_memory.sv */
/*
 * Data memory.
 * Word-wide synchronous RAM with byte write enables,
 * read-first, read data valid one cycle after the request.
 */

`timescale 1ns/1ps

module data_memory (
  input  logic                      clk,
  input  logic                      vld,
  input  degu_pkg::ben_req_t        req,
  output logic [degu_pkg::XLEN-1:0] rdt
);

  // word array, contents survive reset
  logic [degu_pkg::XLEN-1:0] mem [0:2**degu_pkg::MEM_ADR_W-1];

  // word index from the byte address
  logic [degu_pkg::MEM_ADR_W-1:0] idx;

  assign idx = req.adr[degu_pkg::MEM_ADR_W+degu_pkg::BLOG-1:degu_pkg::BLOG];

  always_ff @(posedge clk) begin
    if (vld) begin
      // only enabled lanes are written
      if (req.wen) begin
        for (int b = 0; b < degu_pkg::BLEN; b++) begin
          if (req.ben[b]) begin
            mem[idx][8*b +: 8] <= req.wdt[8*b +: 8];
          end
        end
      end
      // old contents on a write
      rdt <= mem[idx];
    end
  end

endmodule: data_memory

/* source/peripheral_bridge.sv */
/*
 * Peripheral bridge.
 * Registers the peripheral request, decodes the GPIO and
 * UART windows, gives the error response for the UART
 * window and registers the chosen response.
 */

`timescale 1ns/1ps

module peripheral_bridge (
  input  logic               clk,
  input  logic               rst,
  // from the decoder
  input  logic               vld,
  input  degu_pkg::ben_req_t req,
  output logic               rsp_vld,
  output degu_pkg::bus_rsp_t rsp,
  // GPIO controller
  output logic               gpio_vld,
  output degu_pkg::ben_req_t gpio_req,
  input  degu_pkg::bus_rsp_t gpio_rsp
);

  logic               vld_q;
  degu_pkg::ben_req_t req_q;
  logic               sel_uart;
  degu_pkg::bus_rsp_t rsp_d;

  ////////////////////
  // request register
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_q <= 1'b0;
    end else begin
      vld_q <= vld;
    end
  end

  // payload loaded on acceptance only
  always_ff @(posedge clk) begin
    if (vld) begin
      req_q <= req;
    end
  end

  // window decode on the registered address
  assign sel_uart = req_q.adr[degu_pkg::UART_SEL_BIT];

  assign gpio_vld = vld_q & ~sel_uart;
  assign gpio_req = req_q;

  ////////////////////
  // response register
  ////////////////////

  // no UART behind the bridge, error with zero data
  always_comb begin
    if (sel_uart) begin
      rsp_d.rdt = '0;
      rsp_d.err = 1'b1;
    end else begin
      rsp_d = gpio_rsp;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_vld <= 1'b0;
    end else begin
      rsp_vld <= vld_q;
    end
  end

  always_ff @(posedge clk) begin
    if (vld_q) begin
      rsp <= rsp_d;
    end
  end

endmodule: peripheral_bridge

/* source/gpio_controller.sv */
/*
 * GPIO controller.
 * Output and enable registers with byte-enable writes,
 * a two-stage input synchronizer and a combinational
 * read response. The unused offset answers with an error.
 */

`timescale 1ns/1ps

module gpio_controller (
  input  logic                    clk,
  input  logic                    rst,
  // bus side
  input  logic                    vld,
  input  degu_pkg::ben_req_t      req,
  output degu_pkg::bus_rsp_t      rsp,
  // pins
  output logic [degu_pkg::GW-1:0] gpio_o,
  output logic [degu_pkg::GW-1:0] gpio_e,
  input  logic [degu_pkg::GW-1:0] gpio_i
);

  degu_pkg::gpio_reg_t     reg_sel;
  // input synchronizer stages
  logic [degu_pkg::GW-1:0] gpio_s1;
  logic [degu_pkg::GW-1:0] gpio_s2;

  assign reg_sel = degu_pkg::gpio_reg_t'(req.adr[3:2]);

  // output and enable registers
  always_ff @(posedge clk) begin
    if (rst) begin
      gpio_o <= '0;
      gpio_e <= '0;
    end else if (vld && req.wen) begin
      for (int b = 0; b < degu_pkg::BLEN; b++) begin
        if (req.ben[b]) begin
          case (reg_sel)
            degu_pkg::GPIO_OUT: gpio_o[8*b +: 8] <= req.wdt[8*b +: 8];
            degu_pkg::GPIO_ENA: gpio_e[8*b +: 8] <= req.wdt[8*b +: 8];
            // input register is read-only
            default: ;
          endcase
        end
      end
    end
  end

  // two flops against metastability
  always_ff @(posedge clk) begin
    gpio_s1 <= gpio_i;
    gpio_s2 <= gpio_s1;
  end

  // read mux
  always_comb begin
    rsp.rdt = '0;
    rsp.err = 1'b0;
    case (reg_sel)
      degu_pkg::GPIO_OUT:  rsp.rdt = gpio_o;
      degu_pkg::GPIO_ENA:  rsp.rdt = gpio_e;
      degu_pkg::GPIO_IN:   rsp.rdt = gpio_s2;
      degu_pkg::GPIO_NONE: rsp.err = 1'b1;
    endcase
  end

endmodule: gpio_controller

/* source/degu_lsu_top.sv */
/*
 * Degu load/store interconnect top.
 * Lane alignment, address decoder, data memory,
 * peripheral bridge and GPIO controller in one pipeline.
 */

`timescale 1ns/1ps

module degu_lsu_top (
  input  logic                    clk,
  input  logic                    rst,
  // load/store request
  input  logic                    req_vld,
  input  degu_pkg::lsu_req_t      req,
  output logic                    req_rdy,
  // response, no ready
  output logic                    rsp_vld,
  output degu_pkg::bus_rsp_t      rsp,
  // GPIO pins
  output logic [degu_pkg::GW-1:0] gpio_o,
  output logic [degu_pkg::GW-1:0] gpio_e,
  input  logic [degu_pkg::GW-1:0] gpio_i
);

  degu_pkg::ben_req_t        ben_req;
  // memory path
  logic                      mem_vld;
  degu_pkg::ben_req_t        mem_req;
  logic [degu_pkg::XLEN-1:0] mem_rdt;
  // peripheral path
  logic                      per_vld;
  degu_pkg::ben_req_t        per_req;
  logic                      per_rsp_vld;
  degu_pkg::bus_rsp_t        per_rsp;
  logic                      gpio_vld;
  degu_pkg::ben_req_t        gpio_req;
  degu_pkg::bus_rsp_t        gpio_rsp;

  ////////////////////
  // request stages
  ////////////////////

  lsu_lane_align lsu_lane_align_i (
    .req     (req),
    .ben_req (ben_req)
  );

  lsu_bus_decoder lsu_bus_decoder_i (
    .clk         (clk),
    .rst         (rst),
    .req_vld     (req_vld),
    .ben_req     (ben_req),
    .req_rdy     (req_rdy),
    .mem_vld     (mem_vld),
    .mem_req     (mem_req),
    .mem_rdt     (mem_rdt),
    .per_vld     (per_vld),
    .per_req     (per_req),
    .per_rsp_vld (per_rsp_vld),
    .per_rsp     (per_rsp),
    .rsp_vld     (rsp_vld),
    .rsp         (rsp)
  );

  ////////////////////
  // targets
  ////////////////////

  data_memory data_memory_i (
    .clk (clk),
    .vld (mem_vld),
    .req (mem_req),
    .rdt (mem_rdt)
  );

  peripheral_bridge peripheral_bridge_i (
    .clk      (clk),
    .rst      (rst),
    .vld      (per_vld),
    .req      (per_req),
    .rsp_vld  (per_rsp_vld),
    .rsp      (per_rsp),
    .gpio_vld (gpio_vld),
    .gpio_req (gpio_req),
    .gpio_rsp (gpio_rsp)
  );

  gpio_controller gpio_controller_i (
    .clk    (clk),
    .rst    (rst),
    .vld    (gpio_vld),
    .req    (gpio_req),
    .rsp    (gpio_rsp),
    .gpio_o (gpio_o),
    .gpio_e (gpio_e),
    .gpio_i (gpio_i)
  );

endmodule: degu_lsu_top

/* test/tb_clock_gen.sv */
/*
 * Testbench clock source.
 * Free-running clock with a 20 ns period.
 */

`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk
);

  // half of the 20 ns period
  localparam int HALF_NS = 10;

  initial begin
    clk = 1'b0;
    forever begin
      #(HALF_NS) clk = ~clk;
    end
  end

endmodule: tb_clock_gen

/* test/degu_lsu_tb.sv */
/*
 * Testbench for the load/store interconnect.
 * Acts as the core's load/store port: applies a table of requests,
 * keeps a byte-level model of the data memory and the GPIO registers,
 * and checks read data, error flag, latency, order and the one-cycle
 * stall after each peripheral request.
 */

`timescale 1ns/1ps

module degu_lsu_tb;

  // transfer sizes and the level on the GPIO input pins
  localparam degu_pkg::bus_size_t SZ_B = degu_pkg::SIZE_BYTE;
  localparam degu_pkg::bus_size_t SZ_H = degu_pkg::SIZE_HALF;
  localparam degu_pkg::bus_size_t SZ_W = degu_pkg::SIZE_WORD;
  localparam logic [31:0] PIN_VAL = 32'h3c96_a50f;

  // one table row, repeats step the address by the transfer size
  typedef struct packed {
    logic [31:0]         rep;
    logic                rnd;
    logic                wen;
    degu_pkg::bus_size_t size;
    logic [31:0]         adr;
    logic [31:0]         wdt;
    logic                err;
    logic                gchk;
    logic [31:0]         gpio_o;
    logic [31:0]         gpio_e;
    logic [31:0]         lat;
  } row_t;

  // what one accepted request should get back
  typedef struct packed {
    logic [31:0] row;
    logic [31:0] hsk_cyc;
    logic [31:0] lat;
    logic        wen;
    logic        err;
    logic [31:0] rdt;
    logic [31:0] mask;
    logic        gchk;
    logic [31:0] gpio_o;
    logic [31:0] gpio_e;
  } exp_t;

  logic                    clk;
  logic                    rst;
  logic                    req_vld;
  degu_pkg::lsu_req_t      req;
  logic                    req_rdy;
  logic                    rsp_vld;
  degu_pkg::bus_rsp_t      rsp;
  logic [degu_pkg::GW-1:0] gpio_o;
  logic [degu_pkg::GW-1:0] gpio_e;
  logic [degu_pkg::GW-1:0] gpio_i;

  row_t  rows  [$];
  string names [$];
  exp_t  exp_q [$];

  // reference model, memory as bytes
  logic [7:0]  mem_m [0:4095];
  logic [31:0] gpio_o_m;
  logic [31:0] gpio_e_m;

  logic [31:0] cyc = 32'd0;
  logic        per_hsk_q = 1'b0;
  logic        rdy_chk_en = 1'b0;
  bit          table_ready = 1'b0;
  int          val_errs = 0;
  int          proto_errs = 0;
  integer      seed = 59;

  tb_clock_gen tb_clock_gen_i (
    .clk (clk)
  );

  degu_lsu_top degu_lsu_top_i (
    .clk     (clk),
    .rst     (rst),
    .req_vld (req_vld),
    .req     (req),
    .req_rdy (req_rdy),
    .rsp_vld (rsp_vld),
    .rsp     (rsp),
    .gpio_o  (gpio_o),
    .gpio_e  (gpio_e),
    .gpio_i  (gpio_i)
  );

  ////////////////////
  // reference model
  ////////////////////

  // bits of the word that the transfer covers
  function automatic logic [31:0] lane_mask(input degu_pkg::bus_size_t size,
                                            input logic [31:0] adr);
    logic [31:0] m;
    case (size)
      degu_pkg::SIZE_BYTE: m = 32'h0000_00ff;
      degu_pkg::SIZE_HALF: m = 32'h0000_ffff;
      default:             m = 32'hffff_ffff;
    endcase
    return m << (8 * int'(adr[1:0]));
  endfunction

  // address not a multiple of the transfer size
  function automatic logic is_misaligned(input degu_pkg::bus_size_t size,
                                         input logic [31:0] adr);
    return (adr & ((32'd1 << size) - 32'd1)) != 32'd0;
  endfunction

  // whole word around adr, lanes as stored
  function automatic logic [31:0] model_read(input logic [31:0] adr);
    logic [11:0] a;
    a = {adr[11:2], 2'b00};
    if (adr[degu_pkg::PER_SEL_BIT]) begin
      if (adr[degu_pkg::UART_SEL_BIT]) begin
        return 32'd0;
      end
      case (adr[3:2])
        2'd0:    return gpio_o_m;
        2'd1:    return gpio_e_m;
        2'd2:    return PIN_VAL;
        default: return 32'd0;
      endcase
    end
    return {mem_m[a + 12'd3], mem_m[a + 12'd2], mem_m[a + 12'd1], mem_m[a]};
  endfunction

  // little endian, byte k of the data goes to adr+k
  task automatic model_write(input degu_pkg::lsu_req_t q);
    int n;
    int lane;
    n = 1 << int'(q.size);
    // misaligned, UART and read-only targets keep their state
    if (is_misaligned(q.size, q.adr)) begin
      return;
    end
    if (q.adr[degu_pkg::PER_SEL_BIT]) begin
      if (q.adr[degu_pkg::UART_SEL_BIT]) begin
        return;
      end
      for (int k = 0; k < n; k++) begin
        lane = int'(q.adr[1:0]) + k;
        case (q.adr[3:2])
          2'd0:    gpio_o_m[8*lane +: 8] = q.wdt[8*k +: 8];
          2'd1:    gpio_e_m[8*lane +: 8] = q.wdt[8*k +: 8];
          default: ;
        endcase
      end
    end else begin
      for (int k = 0; k < n; k++) begin
        mem_m[q.adr[11:0] + 12'(k)] = q.wdt[8*k +: 8];
      end
    end
  endtask

  ////////////////////
  // stimulus table
  ////////////////////

  task automatic add_row(input string name, input int rep, input int rnd, input int wen,
                         input degu_pkg::bus_size_t size, input logic [31:0] adr,
                         input logic [31:0] wdt, input int err, input int gchk,
                         input logic [31:0] go, input logic [31:0] ge, input int lat);
    row_t r;
    r.rep    = rep;
    r.rnd    = rnd[0];
    r.wen    = wen[0];
    r.size   = size;
    r.adr    = adr;
    r.wdt    = wdt;
    r.err    = err[0];
    r.gchk   = gchk[0];
    r.gpio_o = go;
    r.gpio_e = ge;
    r.lat    = lat;
    rows.push_back(r);
    names.push_back(name);
  endtask

  // name, rep, rnd, wen, size, adr, wdt, err, gpio check, gpio_o, gpio_e, latency
  task automatic build_table();
    // word writes and reads, streamed back to back
    add_row("m_wr_w0",  1, 0, 1, SZ_W, 32'h000000, 32'h12345678, 0, 0, '0, '0, 1);
    add_row("m_wr_w1",  1, 0, 1, SZ_W, 32'h000004, 32'hcafef00d, 0, 0, '0, '0, 1);
    add_row("m_rd_w0",  1, 0, 0, SZ_W, 32'h000000, '0,           0, 0, '0, '0, 1);
    add_row("m_rd_w1",  1, 0, 0, SZ_W, 32'h000004, '0,           0, 0, '0, '0, 1);
    add_row("m_rnd_wr", 8, 1, 1, SZ_W, 32'h000100, '0,           0, 0, '0, '0, 1);
    add_row("m_rnd_rd", 8, 0, 0, SZ_W, 32'h000100, '0,           0, 0, '0, '0, 1);
    // sub-word merges into a known word
    add_row("m_base",   1, 0, 1, SZ_W, 32'h000010, 32'h11111111, 0, 0, '0, '0, 1);
    add_row("m_wr_b",   1, 0, 1, SZ_B, 32'h000011, 32'h000000ab, 0, 0, '0, '0, 1);
    add_row("m_wr_h",   1, 0, 1, SZ_H, 32'h000012, 32'h0000beef, 0, 0, '0, '0, 1);
    add_row("m_rd_mrg", 1, 0, 0, SZ_W, 32'h000010, '0,           0, 0, '0, '0, 1);
    add_row("m_rd_b",   1, 0, 0, SZ_B, 32'h000013, '0,           0, 0, '0, '0, 1);
    add_row("m_rd_h",   1, 0, 0, SZ_H, 32'h000012, '0,           0, 0, '0, '0, 1);
    add_row("m_rnd_b",  4, 1, 1, SZ_B, 32'h000020, '0,           0, 0, '0, '0, 1);
    add_row("m_rd_rb",  1, 0, 0, SZ_W, 32'h000020, '0,           0, 0, '0, '0, 1);
    add_row("m_rnd_h",  2, 1, 1, SZ_H, 32'h000024, '0,           0, 0, '0, '0, 1);
    add_row("m_rd_rh",  1, 0, 0, SZ_W, 32'h000024, '0,           0, 0, '0, '0, 1);
    // misaligned, memory must stay as it was
    add_row("m_mis_h",  1, 0, 1, SZ_H, 32'h000011, 32'h0000dead, 1, 0, '0, '0, 1);
    add_row("m_mis_w",  1, 0, 1, SZ_W, 32'h000012, 32'hdeadbeef, 1, 0, '0, '0, 1);
    add_row("m_mis_rd", 1, 0, 0, SZ_W, 32'h000001, '0,           1, 0, '0, '0, 1);
    add_row("m_rd_chk", 1, 0, 0, SZ_W, 32'h000010, '0,           0, 0, '0, '0, 1);
    // GPIO registers
    add_row("g_wr_out", 1, 0, 1, SZ_W, 32'h200000, 32'ha5a50f0f, 0, 1, 32'ha5a50f0f, '0, 2);
    add_row("g_wr_ena", 1, 0, 1, SZ_W, 32'h200004, 32'h0000ffff, 0, 1, 32'ha5a50f0f,
            32'h0000ffff, 2);
    add_row("g_ena_b",  1, 0, 1, SZ_B, 32'h200006, 32'h3c, 0, 1, 32'ha5a50f0f, 32'h003cffff, 2);
    add_row("g_out_h",  1, 0, 1, SZ_H, 32'h200002, 32'h1234, 0, 1, 32'h12340f0f, 32'h003cffff,
            2);
    add_row("g_rd_out", 1, 0, 0, SZ_W, 32'h200000, '0, 0, 1, 32'h12340f0f, 32'h003cffff, 2);
    add_row("g_rd_ena", 1, 0, 0, SZ_W, 32'h200004, '0, 0, 1, 32'h12340f0f, 32'h003cffff, 2);
    add_row("g_rd_in",  1, 0, 0, SZ_W, 32'h200008, '0, 0, 0, '0, '0, 2);
    add_row("g_rd_inb", 1, 0, 0, SZ_B, 32'h200009, '0, 0, 0, '0, '0, 2);
    add_row("g_wr_in",  1, 0, 1, SZ_W, 32'h200008, 32'hffffffff, 0, 1, 32'h12340f0f,
            32'h003cffff, 2);
    add_row("g_rd_in2", 1, 0, 0, SZ_W, 32'h200008, '0, 0, 0, '0, '0, 2);
    add_row("g_mis",    1, 0, 0, SZ_H, 32'h200001, '0, 1, 0, '0, '0, 1);
    // UART window and the unused GPIO offset
    add_row("u_rd",     1, 0, 0, SZ_W, 32'h200040, '0, 1, 0, '0, '0, 2);
    add_row("u_wr",     1, 0, 1, SZ_W, 32'h200044, 32'hffffffff, 1, 1, 32'h12340f0f,
            32'h003cffff, 2);
    add_row("g_none_r", 1, 0, 0, SZ_W, 32'h20000c, '0, 1, 0, '0, '0, 2);
    add_row("g_none_w", 1, 0, 1, SZ_W, 32'h20000c, 32'hffffffff, 1, 1, 32'h12340f0f,
            32'h003cffff, 2);
    // peripheral then memory straight after, one stall cycle
    add_row("s_per_wr", 1, 0, 1, SZ_W, 32'h200000, 32'h000000ff, 0, 1, 32'h000000ff,
            32'h003cffff, 2);
    add_row("s_mem_wr", 1, 0, 1, SZ_W, 32'h000040, 32'h5555aaaa, 0, 0, '0, '0, 1);
    add_row("s_per_rd", 1, 0, 0, SZ_W, 32'h200000, '0, 0, 1, 32'h000000ff, 32'h003cffff, 2);
    add_row("s_mem_rd", 1, 0, 0, SZ_W, 32'h000040, '0, 0, 0, '0, '0, 1);
  endtask

  ////////////////////
  // driver
  ////////////////////

  // drive one request, wait for the accepting edge, queue the expectation
  task automatic issue_request(input int i, input int r);
    degu_pkg::lsu_req_t nreq;
    exp_t               e;
    logic [31:0]        step;
    step      = 32'd1 << rows[i].size;
    nreq.wen  = rows[i].wen;
    nreq.adr  = rows[i].adr + step * 32'(r);
    nreq.size = rows[i].size;
    nreq.wdt  = rows[i].rnd ? $random(seed) : rows[i].wdt;
    req_vld <= 1'b1;
    req     <= nreq;
    // req_rdy seen here is its level before the edge
    @(posedge clk);
    while (!req_rdy) begin
      @(posedge clk);
    end
    e.row     = i;
    e.hsk_cyc = cyc;
    e.lat     = rows[i].lat;
    e.wen     = nreq.wen;
    e.err     = rows[i].err;
    e.rdt     = model_read(nreq.adr);
    e.mask    = lane_mask(nreq.size, nreq.adr);
    e.gchk    = rows[i].gchk;
    e.gpio_o  = rows[i].gpio_o;
    e.gpio_e  = rows[i].gpio_e;
    if (nreq.wen) begin
      model_write(nreq);
    end
    exp_q.push_back(e);
  endtask

  ////////////////////
  // response checks
  ////////////////////

  task automatic check_response();
    exp_t e;
    if (exp_q.size() == 0) begin
      proto_errs++;
      $display("response arrived with no request outstanding, cycle %0d", cyc);
      return;
    end
    e = exp_q.pop_front();
    assert (cyc - e.hsk_cyc == e.lat) else begin
      val_errs++;
      $display("CHECK FAILED %s latency expected %0d actual %0d", names[e.row], e.lat,
               cyc - e.hsk_cyc);
    end
    assert (rsp.err == e.err) else begin
      val_errs++;
      $display("CHECK FAILED %s err expected %0b actual %0b", names[e.row], e.err, rsp.err);
    end
    if (e.err) begin
      assert (rsp.rdt == 32'd0) else begin
        val_errs++;
        $display("CHECK FAILED %s rdt expected %h actual %h", names[e.row], 32'd0, rsp.rdt);
      end
    end else if (!e.wen) begin
      // only the lanes of the transfer carry data
      assert ((rsp.rdt & e.mask) == (e.rdt & e.mask)) else begin
        val_errs++;
        $display("CHECK FAILED %s rdt expected %h actual %h", names[e.row], e.rdt & e.mask,
                 rsp.rdt & e.mask);
      end
    end
    if (e.gchk) begin
      assert (gpio_o == e.gpio_o) else begin
        val_errs++;
        $display("CHECK FAILED %s gpio_o expected %h actual %h", names[e.row], e.gpio_o,
                 gpio_o);
      end
      assert (gpio_e == e.gpio_e) else begin
        val_errs++;
        $display("CHECK FAILED %s gpio_e expected %h actual %h", names[e.row], e.gpio_e,
                 gpio_e);
      end
    end
  endtask

  // cycle count, ready rule and responses, all sampled at the edge
  always @(posedge clk) begin
    cyc <= cyc + 32'd1;
    if (rdy_chk_en) begin
      if (per_hsk_q) begin
        assert (!req_rdy) else begin
          proto_errs++;
          $display("req_rdy high in the cycle after a peripheral handshake, cycle %0d", cyc);
        end
      end else begin
        assert (req_rdy) else begin
          proto_errs++;
          $display("req_rdy low with no peripheral handshake before it, cycle %0d", cyc);
        end
      end
    end
    per_hsk_q <= req_vld && req_rdy && req.adr[degu_pkg::PER_SEL_BIT] &&
                 !is_misaligned(req.size, req.adr);
    if (rsp_vld) begin
      check_response();
    end
  end

  ////////////////////
  // sequence
  ////////////////////

  initial begin
    req_vld <= 1'b0;
    req     <= '0;
    rst     <= 1'b1;
    gpio_i  <= PIN_VAL;
    // register state right after reset
    gpio_o_m = '0;
    gpio_e_m = '0;
    build_table();
    table_ready = 1'b1;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    repeat (2) @(posedge clk);
    rdy_chk_en <= 1'b1;
    for (int i = 0; i < rows.size(); i++) begin
      for (int r = 0; r < rows[i].rep; r++) begin
        issue_request(i, r);
      end
    end
    req_vld <= 1'b0;
    // let the last responses come back
    for (int k = 0; k < 20; k++) begin
      if (exp_q.size() == 0) begin
        break;
      end
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
    assert (exp_q.size() == 0) else begin
      proto_errs++;
      $display("%0d responses never arrived", exp_q.size());
    end
    $display("checks done: %0d value errors, %0d protocol errors", val_errs, proto_errs);
    if (val_errs == 0 && proto_errs == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // watchdog, ten cycles per table row plus reset
  initial begin
    wait (table_ready);
    #((rows.size() * 10 + 4) * 20);
    $display("watchdog expired, the request sequence did not complete in time");
    $display("TEST FAILED");
    $finish;
  end

endmodule: degu_lsu_tb

/* degu_lsu.f */
source/degu_pkg.sv
source/lsu_lane_align.sv
source/lsu_bus_decoder.sv
source/data_memory.sv
source/peripheral_bridge.sv
source/gpio_controller.sv
source/degu_lsu_top.sv
test/tb_clock_gen.sv
test/degu_lsu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the load/store interconnect testbench with Verilator and run it
# pass only when the simulation prints its pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module degu_lsu_tb \
  -f degu_lsu.f \
  -Mdir obj_dir \
  && ./obj_dir/Vdegu_lsu_tb | tee /dev/stderr | grep -x "TEST OK" > /dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
